/* alu_cluster.f */
+incdir+design
design/alu_cluster_pkg.sv
design/rs_alu.sv
design/alu_exec.sv
design/alu_cluster.sv
tb/tb_alu_cluster.sv

/* tb/tb_alu_cluster.sv */
`include "alu_cluster_defines.svh"
`default_nettype none

module tb_alu_cluster
    import alu_cluster_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 3000;
    localparam int RANDOM_CNT     = 200;

    logic         clk;
    logic         rst;
    logic         rdy;
    logic         dispatch_en0;
    logic         dispatch_en1;
    rs_dispatch_t dispatch0;
    rs_dispatch_t dispatch1;
    result_bus_t  ls_bus;
    logic         slot_free0;
    logic         slot_free1;
    result_bus_t  alu_bus0;
    result_bus_t  alu_bus1;
    int           cycles = 0;

    alu_cluster i_dut (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .dispatch_en0 (dispatch_en0),
        .dispatch_en1 (dispatch_en1),
        .dispatch0    (dispatch0),
        .dispatch1    (dispatch1),
        .ls_bus       (ls_bus),
        .slot_free0   (slot_free0),
        .slot_free1   (slot_free1),
        .alu_bus0     (alu_bus0),
        .alu_bus1     (alu_bus1)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // Expected ALU result.
    function automatic word_t alu_ref(input alu_op_t op, input addr_t pc,
                                      input word_t x, input word_t y);
        case (op)
            OP_ADD:   return x + y;
            OP_SUB:   return x - y;
            OP_AND:   return x & y;
            OP_OR:    return x | y;
            OP_XOR:   return x ^ y;
            OP_SLL:   return x << y[4:0];
            OP_SRL:   return x >> y[4:0];
            OP_SRA:   return $signed(x) >>> y[4:0];
            OP_SLT:   return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            OP_SLTU:  return (x < y) ? 32'd1 : 32'd0;
            OP_LUI:   return y;
            OP_AUIPC: return pc + y;
            default:  return '0;
        endcase
    endfunction

    task automatic stop_with_failure();
        $display("TB FAILED");
        $fatal(1, "Run stopped at the first failure.");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
            stop_with_failure();
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Mismatch at %0t ns: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_bus(input int slot, input logic valid, input tag_t tag,
                             input reg_addr_t target, input word_t data);
        result_bus_t bus;
        bus = (slot == 0) ? alu_bus0 : alu_bus1;
        check_value($sformatf("alu_bus%0d.valid", slot), valid, bus.valid);
        if (valid) begin
            check_value($sformatf("alu_bus%0d.tag", slot), tag, bus.tag);
            check_value($sformatf("alu_bus%0d.target", slot), target, bus.target);
            check_value($sformatf("alu_bus%0d.data", slot), data, bus.data);
        end
    endtask

    task automatic check_free(input int slot, input logic free);
        check_value($sformatf("slot_free%0d", slot), free,
                    (slot == 0) ? slot_free0 : slot_free1);
    endtask

    function automatic rs_dispatch_t make_dispatch(input alu_op_t op, input tag_t tag_x,
                                                   input tag_t tag_y, input tag_t tag_w,
                                                   input word_t x, input word_t y);
        rs_dispatch_t d;
        d.pc     = $urandom();
        d.op     = op;
        d.tag_x  = tag_x;
        d.tag_y  = tag_y;
        d.tag_w  = tag_w;
        d.data_x = x;
        d.data_y = y;
        d.target = reg_addr_t'($urandom());
        return d;
    endfunction

    task automatic drive_dispatch(input int slot, input rs_dispatch_t d);
        if (slot == 0) begin
            dispatch_en0 = 1'b1;
            dispatch0    = d;
        end else begin
            dispatch_en1 = 1'b1;
            dispatch1    = d;
        end
    endtask

    task automatic clear_inputs();
        dispatch_en0 = 1'b0;
        dispatch_en1 = 1'b0;
        ls_bus.valid = 1'b0;
    endtask

    // Result due in the second cycle after the coming edge.
    task automatic check_fixed_latency(input int slot, input rs_dispatch_t d, input word_t exp);
        @(negedge clk);
        clear_inputs();
        check_bus(slot, 1'b0, d.tag_w, d.target, exp);
        check_free(slot, 1'b0);
        @(negedge clk);
        check_bus(slot, 1'b1, d.tag_w, d.target, exp);
        check_free(slot, 1'b1);
        @(negedge clk);
        check_bus(slot, 1'b0, d.tag_w, d.target, exp);
    endtask

    task automatic test_reset();
        check_free(0, 1'b1);
        check_free(1, 1'b1);
        check_bus(0, 1'b0, '0, '0, '0);
        check_bus(1, 1'b0, '0, '0, '0);
    endtask

    task automatic test_ready_operands();
        rs_dispatch_t d;
        d = make_dispatch(OP_ADD, `UNLOCKED, `UNLOCKED, 4'd7, $urandom(), $urandom());
        drive_dispatch(0, d);
        check_fixed_latency(0, d, alu_ref(d.op, d.pc, d.data_x, d.data_y));
    endtask

    task automatic test_all_ops();
        rs_dispatch_t d;
        for (int i = 0; i < RANDOM_CNT; i++) begin
            // Each slot walks through all twelve ops.
            d = make_dispatch(alu_op_t'((i / 2) % 12), `UNLOCKED, `UNLOCKED,
                              tag_t'($urandom_range(15, 1)), $urandom(), $urandom());
            drive_dispatch(i % 2, d);
            check_fixed_latency(i % 2, d, alu_ref(d.op, d.pc, d.data_x, d.data_y));
        end
    endtask

    task automatic test_ls_wait();
        rs_dispatch_t d;
        int           gap;
        word_t        ls_data;
        d       = make_dispatch(OP_SUB, 4'd5, `UNLOCKED, 4'd9, $urandom(), $urandom());
        gap     = $urandom_range(8, 1);
        ls_data = $urandom();
        drive_dispatch(0, d);
        @(negedge clk);
        clear_inputs();
        // An unrelated tag is ignored.
        ls_bus = '{valid: 1'b1, tag: 4'd6, data: ~ls_data, target: '0};
        repeat (gap) begin
            @(negedge clk);
            clear_inputs();
            check_bus(0, 1'b0, '0, '0, '0);
            check_free(0, 1'b0);
        end
        ls_bus = '{valid: 1'b1, tag: 4'd5, data: ls_data, target: '0};
        check_fixed_latency(0, d, alu_ref(d.op, d.pc, ls_data, d.data_y));
        // Broadcast in the dispatch cycle itself.
        d       = make_dispatch(OP_XOR, `UNLOCKED, 4'd11, 4'd12, $urandom(), $urandom());
        ls_data = $urandom();
        drive_dispatch(1, d);
        ls_bus = '{valid: 1'b1, tag: 4'd11, data: ls_data, target: '0};
        check_fixed_latency(1, d, alu_ref(d.op, d.pc, d.data_x, ls_data));
    endtask

    task automatic test_forwarding();
        rs_dispatch_t d0;
        rs_dispatch_t d1;
        word_t        r0;
        d0 = make_dispatch(OP_ADD, `UNLOCKED, `UNLOCKED, 4'd3, $urandom(), $urandom());
        d1 = make_dispatch(OP_SLL, 4'd3, `UNLOCKED, 4'd4, $urandom(), $urandom());
        r0 = alu_ref(d0.op, d0.pc, d0.data_x, d0.data_y);
        drive_dispatch(0, d0);
        drive_dispatch(1, d1);
        @(negedge clk);
        clear_inputs();
        check_bus(0, 1'b0, '0, '0, '0);
        check_bus(1, 1'b0, '0, '0, '0);
        @(negedge clk);
        check_bus(0, 1'b1, d0.tag_w, d0.target, r0);
        check_bus(1, 1'b0, '0, '0, '0);
        // Slot 1 picks up alu_bus0 at the coming edge.
        check_fixed_latency(1, d1, alu_ref(d1.op, d1.pc, r0, d1.data_y));
    endtask

    task automatic test_stall();
        rs_dispatch_t d;
        int           hold;
        word_t        exp;
        d    = make_dispatch(OP_SRA, `UNLOCKED, `UNLOCKED, 4'd13, $urandom(), $urandom());
        exp  = alu_ref(d.op, d.pc, d.data_x, d.data_y);
        hold = $urandom_range(6, 2);
        drive_dispatch(0, d);
        @(negedge clk);
        clear_inputs();
        rdy = 1'b0;
        repeat (hold) begin
            @(negedge clk);
            check_bus(0, 1'b0, '0, '0, '0);
            check_free(0, 1'b0);
        end
        rdy = 1'b1;
        @(negedge clk);
        check_bus(0, 1'b1, d.tag_w, d.target, exp);
        check_free(0, 1'b1);
        // A valid bus is held through a stall.
        d   = make_dispatch(OP_OR, `UNLOCKED, `UNLOCKED, 4'd14, $urandom(), $urandom());
        exp = alu_ref(d.op, d.pc, d.data_x, d.data_y);
        drive_dispatch(1, d);
        @(negedge clk);
        clear_inputs();
        check_bus(0, 1'b0, '0, '0, '0);
        @(negedge clk);
        check_bus(1, 1'b1, d.tag_w, d.target, exp);
        rdy = 1'b0;
        @(negedge clk);
        check_bus(1, 1'b1, d.tag_w, d.target, exp);
        check_free(1, 1'b1);
        rdy = 1'b1;
        @(negedge clk);
        check_bus(1, 1'b0, '0, '0, '0);
    endtask

    initial begin
        void'($urandom(32'he4da_d18a));
        rst          = 1'b1;
        rdy          = 1'b1;
        dispatch_en0 = 1'b0;
        dispatch_en1 = 1'b0;
        dispatch0    = '0;
        dispatch1    = '0;
        ls_bus       = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        test_reset();
        test_ready_operands();
        test_all_ops();
        repeat (4) test_ls_wait();
        test_forwarding();
        test_stall();
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* design/alu_cluster.sv */
`include "alu_cluster_defines.svh"
`default_nettype none

module alu_cluster
    import alu_cluster_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         rdy,

    input  logic         dispatch_en0,
    input  logic         dispatch_en1,
    input  rs_dispatch_t dispatch0,
    input  rs_dispatch_t dispatch1,

    // Load/store unit results.
    input  result_bus_t  ls_bus,

    output logic         slot_free0,
    output logic         slot_free1,
    output result_bus_t  alu_bus0,
    output result_bus_t  alu_bus1
);

    logic      issue_en0;
    logic      issue_en1;
    rs_issue_t issue0;
    rs_issue_t issue1;

    // Executor buses feed back for forwarding.
    rs_alu i_rs_alu (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .dispatch_en0 (dispatch_en0),
        .dispatch_en1 (dispatch_en1),
        .dispatch0    (dispatch0),
        .dispatch1    (dispatch1),
        .alu_bus0     (alu_bus0),
        .alu_bus1     (alu_bus1),
        .ls_bus       (ls_bus),
        .slot_free0   (slot_free0),
        .slot_free1   (slot_free1),
        .issue_en0    (issue_en0),
        .issue_en1    (issue_en1),
        .issue0       (issue0),
        .issue1       (issue1)
    );

    alu_exec i_alu_exec0 (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .issue_en   (issue_en0),
        .issue      (issue0),
        .result_bus (alu_bus0)
    );

    alu_exec i_alu_exec1 (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .issue_en   (issue_en1),
        .issue      (issue1),
        .result_bus (alu_bus1)
    );

endmodule

`default_nettype wire

/* design/alu_exec.sv */
`include "alu_cluster_defines.svh"
`default_nettype none

module alu_exec
    import alu_cluster_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        rdy,

    input  logic        issue_en,
    input  rs_issue_t   issue,

    output result_bus_t result_bus
);

    localparam int SHAMT_W = $clog2(`WORD_W);

    logic [SHAMT_W-1:0] shamt;
    word_t              sum;
    word_t              diff;
    word_t              pc_sum;
    logic               lt_s;
    logic               lt_u;
    word_t              result;

    // Registered bus.
    logic      valid_q;
    tag_t      tag_q;
    word_t     data_q;
    reg_addr_t target_q;

    assign shamt  = issue.data_y[SHAMT_W-1:0];
    assign sum    = issue.data_x + issue.data_y;
    assign diff   = issue.data_x - issue.data_y;
    assign pc_sum = issue.pc + issue.data_y;

    assign lt_s = $signed(issue.data_x) < $signed(issue.data_y);
    assign lt_u = issue.data_x < issue.data_y;

    always_comb begin
        case (issue.op)
            OP_ADD: begin
                result = sum;
            end
            OP_SUB: begin
                result = diff;
            end
            OP_AND: begin
                result = issue.data_x & issue.data_y;
            end
            OP_OR: begin
                result = issue.data_x | issue.data_y;
            end
            OP_XOR: begin
                result = issue.data_x ^ issue.data_y;
            end
            OP_SLL: begin
                result = issue.data_x << shamt;
            end
            OP_SRL: begin
                result = issue.data_x >> shamt;
            end
            OP_SRA: begin
                result = $signed(issue.data_x) >>> shamt;
            end
            OP_SLT: begin
                result = {{(`WORD_W-1){1'b0}}, lt_s};
            end
            OP_SLTU: begin
                result = {{(`WORD_W-1){1'b0}}, lt_u};
            end
            // Upper immediate arrives ready in operand y.
            OP_LUI: begin
                result = issue.data_y;
            end
            OP_AUIPC: begin
                result = pc_sum;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // Valid lasts one cycle, held while stalled.
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (rdy) begin
            valid_q <= issue_en;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_en) begin
            tag_q    <= issue.tag_w;
            data_q   <= result;
            target_q <= issue.target;
        end
    end

    assign result_bus = '{valid:  valid_q,
                          tag:    tag_q,
                          data:   data_q,
                          target: target_q};

endmodule

`default_nettype wire

/* design/rs_alu.sv */
`include "alu_cluster_defines.svh"
`default_nettype none

module rs_alu
    import alu_cluster_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         rdy,

    input  logic         dispatch_en0,
    input  logic         dispatch_en1,
    input  rs_dispatch_t dispatch0,
    input  rs_dispatch_t dispatch1,

    input  result_bus_t  alu_bus0,
    input  result_bus_t  alu_bus1,
    input  result_bus_t  ls_bus,

    output logic         slot_free0,
    output logic         slot_free1,

    output logic         issue_en0,
    output logic         issue_en1,
    output rs_issue_t    issue0,
    output rs_issue_t    issue1
);

    localparam int BUS_CNT = 3;

    logic [`ALU_CNT-1:0]       disp_en;
    rs_dispatch_t              disp [`ALU_CNT];
    result_bus_t [BUS_CNT-1:0] buses;

    // Slot state.
    logic [`ALU_CNT-1:0] busy;
    addr_t               pc     [`ALU_CNT];
    alu_op_t             op     [`ALU_CNT];
    tag_t                tag_x  [`ALU_CNT];
    tag_t                tag_y  [`ALU_CNT];
    tag_t                tag_w  [`ALU_CNT];
    word_t               data_x [`ALU_CNT];
    word_t               data_y [`ALU_CNT];
    reg_addr_t           target [`ALU_CNT];

    // Operands after the snoop rule.
    tag_t  nxt_tag_x  [`ALU_CNT];
    tag_t  nxt_tag_y  [`ALU_CNT];
    word_t nxt_data_x [`ALU_CNT];
    word_t nxt_data_y [`ALU_CNT];

    logic [`ALU_CNT-1:0] ready;
    rs_issue_t           iss [`ALU_CNT];

    assign disp_en = {dispatch_en1, dispatch_en0};
    assign disp[0] = dispatch0;
    assign disp[1] = dispatch1;
    assign buses   = {ls_bus, alu_bus1, alu_bus0};

    // Pending operand picks up a matching broadcast.
    function automatic void snoop(
        input  tag_t                      tag_in,
        input  word_t                     data_in,
        input  result_bus_t [BUS_CNT-1:0] bus,
        output tag_t                      tag_out,
        output word_t                     data_out
    );
        tag_out  = tag_in;
        data_out = data_in;
        for (int b = 0; b < BUS_CNT; b++) begin
            if (tag_in != `UNLOCKED && bus[b].valid && bus[b].tag == tag_in) begin
                tag_out  = `UNLOCKED;
                data_out = bus[b].data;
            end
        end
    endfunction

    // Dispatch fields are snooped too, so a same-cycle result is not lost.
    always_comb begin
        for (int i = 0; i < `ALU_CNT; i++) begin
            if (disp_en[i]) begin
                snoop(disp[i].tag_x, disp[i].data_x, buses, nxt_tag_x[i], nxt_data_x[i]);
                snoop(disp[i].tag_y, disp[i].data_y, buses, nxt_tag_y[i], nxt_data_y[i]);
            end else begin
                snoop(tag_x[i], data_x[i], buses, nxt_tag_x[i], nxt_data_x[i]);
                snoop(tag_y[i], data_y[i], buses, nxt_tag_y[i], nxt_data_y[i]);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `ALU_CNT; i++) begin
            ready[i] = rdy && busy[i] && tag_x[i] == `UNLOCKED && tag_y[i] == `UNLOCKED;
            iss[i]   = '{pc:     pc[i],
                         op:     op[i],
                         tag_w:  tag_w[i],
                         data_x: data_x[i],
                         data_y: data_y[i],
                         target: target[i]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
            for (int i = 0; i < `ALU_CNT; i++) begin
                tag_x[i] <= `UNLOCKED;
                tag_y[i] <= `UNLOCKED;
            end
        end else if (rdy) begin
            for (int i = 0; i < `ALU_CNT; i++) begin
                // A strobe on a busy slot overwrites it.
                if (disp_en[i]) begin
                    busy[i] <= 1'b1;
                end else if (ready[i]) begin
                    busy[i] <= 1'b0;
                end
                tag_x[i] <= nxt_tag_x[i];
                tag_y[i] <= nxt_tag_y[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            for (int i = 0; i < `ALU_CNT; i++) begin
                if (disp_en[i]) begin
                    pc[i]     <= disp[i].pc;
                    op[i]     <= disp[i].op;
                    tag_w[i]  <= disp[i].tag_w;
                    target[i] <= disp[i].target;
                end
                data_x[i] <= nxt_data_x[i];
                data_y[i] <= nxt_data_y[i];
            end
        end
    end

    assign slot_free0 = ~busy[0];
    assign slot_free1 = ~busy[1];
    assign issue_en0  = ready[0];
    assign issue_en1  = ready[1];
    assign issue0     = iss[0];
    assign issue1     = iss[1];

endmodule

`default_nettype wire

/* design/alu_cluster_pkg.sv */
`include "alu_cluster_defines.svh"
`default_nettype none

package alu_cluster_pkg;

    typedef logic [`WORD_W-1:0]    word_t;
    typedef logic [`ADDR_W-1:0]    addr_t;
    typedef logic [`TAG_W-1:0]     tag_t;
    typedef logic [`REGADDR_W-1:0] reg_addr_t;

    // Station-level instruction code.
    typedef logic [3:0] alu_op_t;

    localparam alu_op_t OP_ADD   = 4'd0;
    localparam alu_op_t OP_SUB   = 4'd1;
    localparam alu_op_t OP_AND   = 4'd2;
    localparam alu_op_t OP_OR    = 4'd3;
    localparam alu_op_t OP_XOR   = 4'd4;
    localparam alu_op_t OP_SLL   = 4'd5;
    localparam alu_op_t OP_SRL   = 4'd6;
    localparam alu_op_t OP_SRA   = 4'd7;
    localparam alu_op_t OP_SLT   = 4'd8;
    localparam alu_op_t OP_SLTU  = 4'd9;
    localparam alu_op_t OP_LUI   = 4'd10;
    localparam alu_op_t OP_AUIPC = 4'd11;

    // Decoded instruction from the dispatcher.
    typedef struct packed {
        addr_t     pc;
        alu_op_t   op;
        tag_t      tag_x;
        tag_t      tag_y;
        tag_t      tag_w;
        word_t     data_x;
        word_t     data_y;
        reg_addr_t target;
    } rs_dispatch_t;

    // Instruction with both operands resolved.
    typedef struct packed {
        addr_t     pc;
        alu_op_t   op;
        tag_t      tag_w;
        word_t     data_x;
        word_t     data_y;
        reg_addr_t target;
    } rs_issue_t;

    typedef struct packed {
        logic      valid;
        tag_t      tag;
        word_t     data;
        reg_addr_t target;
    } result_bus_t;

endpackage

`default_nettype wire

/* design/alu_cluster_defines.svh */
`ifndef ALU_CLUSTER_DEFINES_SVH
`define ALU_CLUSTER_DEFINES_SVH

// Data and program counter widths.
`define WORD_W 32
`define ADDR_W 32

// Rename tag width. Real tags run from 1 up.
`define TAG_W 4

// Architectural register address width.
`define REGADDR_W 5

// One station slot per ALU executor.
`define ALU_CNT 2

// Operand holds its value, nothing pending.
`define UNLOCKED {`TAG_W{1'b0}}

`endif
